/* flist.f */
hdl/axi4_reader_pkg.sv
hdl/cmd_splitter.sv
hdl/stream_fifo.sv
hdl/burst_gen.sv
hdl/last_gen.sv
hdl/axi4_reader.sv
tb/axi4_slave_model.sv
tb/axi4_reader_properties.sv
tb/axi4_reader_tb.sv

/* hdl/axi4_reader.sv */
// --------------------------------------
// axi4_reader: top level of the AXI4
// burst read engine with stream output
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi4_reader #(
	parameter int ALIGN          = 12,
	parameter int DATA_PTR_WIDTH = 9,
	parameter int LAST_PTR_WIDTH = 6
) (
	input  wire                     aclk,
	input  wire                     rst,
	output logic                    busy,
	input  wire axi4_reader_pkg::addr_t  param_range_start,
	input  wire axi4_reader_pkg::addr_t  param_range_end,
	input  wire axi4_reader_pkg::axlen_t param_maxlen,
	input  wire axi4_reader_pkg::addr_t  s_araddr,
	input  wire axi4_reader_pkg::len_t   s_arlen,
	input  wire                     s_arvalid,
	output logic                    s_arready,
	output axi4_reader_pkg::addr_t  m_axi4_araddr,
	output axi4_reader_pkg::axlen_t m_axi4_arlen,
	output logic [2:0]              m_axi4_arsize,
	output logic [1:0]              m_axi4_arburst,
	output logic [3:0]              m_axi4_arcache,
	output logic [2:0]              m_axi4_arprot,
	output logic                    m_axi4_arvalid,
	input  wire                     m_axi4_arready,
	input  wire axi4_reader_pkg::data_t  m_axi4_rdata,
	input  wire                     m_axi4_rlast,
	input  wire                     m_axi4_rvalid,
	output logic                    m_axi4_rready,
	output axi4_reader_pkg::data_t  m_axi4s_tdata,
	output logic                    m_axi4s_tlast,
	output logic                    m_axi4s_tvalid,
	input  wire                     m_axi4s_tready
);
	import axi4_reader_pkg::*;

	addr_t core_addr;
	len_t  core_len;
	logic  core_valid;
	logic  core_ready;
	len_t  last_len;
	logic  last_valid;
	logic  last_ready;
	logic  core_busy;
	logic  last_busy;
	beat_t r_beat;
	beat_t fifo_beat;
	logic  fifo_valid;
	logic  fifo_ready;

	cmd_splitter u_splitter (
		.aclk       (aclk),
		.rst        (rst),
		.s_addr     (s_araddr),
		.s_len      (s_arlen),
		.s_valid    (s_arvalid),
		.s_ready    (s_arready),
		.core_addr  (core_addr),
		.core_len   (core_len),
		.core_valid (core_valid),
		.core_ready (core_ready),
		.last_len   (last_len),
		.last_valid (last_valid),
		.last_ready (last_ready)
	);

	// ----------------------------------
	// address side
	// ----------------------------------
	burst_gen #(
		.ALIGN        (ALIGN),
		.CREDIT_WIDTH (DATA_PTR_WIDTH + 1)
	) u_burst_gen (
		.aclk              (aclk),
		.rst               (rst),
		.param_range_start (param_range_start),
		.param_range_end   (param_range_end),
		.param_maxlen      (param_maxlen),
		.s_addr            (core_addr),
		.s_len             (core_len),
		.s_valid           (core_valid),
		.s_ready           (core_ready),
		.credit_ret        (m_axi4s_tvalid && m_axi4s_tready),
		.m_axi4_araddr     (m_axi4_araddr),
		.m_axi4_arlen      (m_axi4_arlen),
		.m_axi4_arsize     (m_axi4_arsize),
		.m_axi4_arburst    (m_axi4_arburst),
		.m_axi4_arcache    (m_axi4_arcache),
		.m_axi4_arprot     (m_axi4_arprot),
		.m_axi4_arvalid    (m_axi4_arvalid),
		.m_axi4_arready    (m_axi4_arready),
		.busy              (core_busy)
	);

	// ----------------------------------
	// data side
	// ----------------------------------
	assign r_beat = '{data: m_axi4_rdata, last: m_axi4_rlast};

	stream_fifo #(
		.payload_t (beat_t),
		.PTR_WIDTH (DATA_PTR_WIDTH)
	) u_data_fifo (
		.aclk    (aclk),
		.rst     (rst),
		.s_data  (r_beat),
		.s_valid (m_axi4_rvalid),
		.s_ready (m_axi4_rready),
		.m_data  (fifo_beat),
		.m_valid (fifo_valid),
		.m_ready (fifo_ready)
	);

	last_gen #(
		.PTR_WIDTH (LAST_PTR_WIDTH)
	) u_last_gen (
		.aclk      (aclk),
		.rst       (rst),
		.cmd_len   (last_len),
		.cmd_valid (last_valid),
		.cmd_ready (last_ready),
		.s_data    (fifo_beat.data),
		.s_valid   (fifo_valid),
		.s_ready   (fifo_ready),
		.m_tdata   (m_axi4s_tdata),
		.m_tlast   (m_axi4s_tlast),
		.m_tvalid  (m_axi4s_tvalid),
		.m_tready  (m_axi4s_tready),
		.busy      (last_busy)
	);

	assign busy = core_valid || last_valid || core_busy || last_busy;

endmodule

`default_nettype wire

/* hdl/axi4_reader_pkg.sv */
// --------------------------------------
// bus widths, fixed AXI4 read address
// fields and payload types
// --------------------------------------
`default_nettype none

package axi4_reader_pkg;

	localparam int addr_w    = 32;
	localparam int data_size = 2;
	localparam int data_w    = 8 << data_size;
	localparam int len_w     = 24;
	localparam int axlen_w   = 8;

	// INCR, one word per beat
	localparam logic [1:0] ar_burst = 2'b01;
	localparam logic [2:0] ar_size  = 3'(data_size);
	localparam logic [3:0] ar_cache = 4'b0001;
	localparam logic [2:0] ar_prot  = 3'b000;

	typedef logic [addr_w-1:0]  addr_t;
	typedef logic [len_w-1:0]   len_t;
	typedef logic [axlen_w-1:0] axlen_t;
	typedef logic [data_w-1:0]  data_t;

	typedef struct packed {
		data_t data;
		logic  last;
	} beat_t;

endpackage

`default_nettype wire

/* hdl/burst_gen.sv */
// --------------------------------------
// burst_gen: cuts requests into AXI4
// bursts, wraps the window, gates AR on
// output FIFO credits
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module burst_gen #(
	parameter int ALIGN        = 12,
	parameter int CREDIT_WIDTH = 10
) (
	input  wire                     aclk,
	input  wire                     rst,
	input  wire axi4_reader_pkg::addr_t  param_range_start,
	input  wire axi4_reader_pkg::addr_t  param_range_end,
	input  wire axi4_reader_pkg::axlen_t param_maxlen,
	input  wire axi4_reader_pkg::addr_t  s_addr,
	input  wire axi4_reader_pkg::len_t   s_len,
	input  wire                     s_valid,
	output logic                    s_ready,
	input  wire                     credit_ret,
	output axi4_reader_pkg::addr_t  m_axi4_araddr,
	output axi4_reader_pkg::axlen_t m_axi4_arlen,
	output logic [2:0]              m_axi4_arsize,
	output logic [1:0]              m_axi4_arburst,
	output logic [3:0]              m_axi4_arcache,
	output logic [2:0]              m_axi4_arprot,
	output logic                    m_axi4_arvalid,
	input  wire                     m_axi4_arready,
	output logic                    busy
);
	import axi4_reader_pkg::*;

	localparam int credit_init = 1 << (CREDIT_WIDTH - 1);
	localparam int align_words = 1 << (ALIGN - data_size);

	logic                    active;
	addr_t                   cur_addr;
	logic [len_w:0]          remain;
	logic [CREDIT_WIDTH-1:0] credits;
	logic [CREDIT_WIDTH-1:0] spend;
	addr_t                   to_align;
	addr_t                   to_end;
	addr_t                   lim;
	addr_t                   next_addr;
	logic                    load;
	logic                    ar_fire;

	// ----------------------------------
	// burst size and next address
	// ----------------------------------
	always_comb begin
		to_align = addr_t'(align_words) - addr_t'(cur_addr[ALIGN-1:data_size]);
		to_end   = (param_range_end - cur_addr) >> data_size;
		lim      = addr_t'(remain);
		if (addr_t'(param_maxlen) + 1 < lim)
			lim = addr_t'(param_maxlen) + 1;
		if (to_align < lim)
			lim = to_align;
		if (to_end < lim)
			lim = to_end;
		// never more than the FIFO holds
		if (addr_t'(credit_init) < lim)
			lim = addr_t'(credit_init);
		next_addr = cur_addr + (lim << data_size);
		if (next_addr == param_range_end)
			next_addr = param_range_start;
	end

	assign load    = active && !m_axi4_arvalid && remain != '0 && addr_t'(credits) >= lim;
	assign ar_fire = m_axi4_arvalid && m_axi4_arready;
	assign spend   = ar_fire ? CREDIT_WIDTH'(m_axi4_arlen) + CREDIT_WIDTH'(1) : '0;
	assign s_ready = !active;
	assign busy    = active;

	assign m_axi4_arsize  = ar_size;
	assign m_axi4_arburst = ar_burst;
	assign m_axi4_arcache = ar_cache;
	assign m_axi4_arprot  = ar_prot;

	always_ff @(posedge aclk) begin
		if (rst) begin
			active         <= 1'b0;
			m_axi4_arvalid <= 1'b0;
			credits        <= CREDIT_WIDTH'(credit_init);
		end else begin
			if (s_valid && s_ready)
				active <= 1'b1;
			else if (ar_fire && remain == '0)
				active <= 1'b0;
			if (load)
				m_axi4_arvalid <= 1'b1;
			else if (ar_fire)
				m_axi4_arvalid <= 1'b0;
			credits <= credits + CREDIT_WIDTH'(credit_ret) - spend;
		end
	end

	always_ff @(posedge aclk) begin
		if (s_valid && s_ready) begin
			cur_addr <= s_addr;
			remain   <= {1'b0, s_len} + 1'b1;
		end else if (load) begin
			cur_addr      <= next_addr;
			remain        <= remain - lim[len_w:0];
			m_axi4_araddr <= cur_addr;
			m_axi4_arlen  <= axlen_t'(lim - 1);
		end
	end

endmodule

`default_nettype wire

/* hdl/cmd_splitter.sv */
// --------------------------------------
// cmd_splitter: one request register,
// two independent consumer copies
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cmd_splitter (
	input  wire                    aclk,
	input  wire                    rst,
	input  wire axi4_reader_pkg::addr_t s_addr,
	input  wire axi4_reader_pkg::len_t  s_len,
	input  wire                    s_valid,
	output logic                   s_ready,
	output axi4_reader_pkg::addr_t core_addr,
	output axi4_reader_pkg::len_t  core_len,
	output logic                   core_valid,
	input  wire                    core_ready,
	output axi4_reader_pkg::len_t  last_len,
	output logic                   last_valid,
	input  wire                    last_ready
);
	import axi4_reader_pkg::*;

	addr_t req_addr;
	len_t  req_len;

	assign core_addr = req_addr;
	assign core_len  = req_len;
	assign last_len  = req_len;

	always_ff @(posedge aclk) begin
		if (rst) begin
			core_valid <= 1'b0;
			last_valid <= 1'b0;
			s_ready    <= 1'b0;
		end else if (s_valid && s_ready) begin
			core_valid <= 1'b1;
			last_valid <= 1'b1;
			s_ready    <= 1'b0;
		end else begin
			// each copy drops on its own consumer
			if (core_ready)
				core_valid <= 1'b0;
			if (last_ready)
				last_valid <= 1'b0;
			s_ready <= (!core_valid || core_ready) && (!last_valid || last_ready);
		end
	end

	always_ff @(posedge aclk) begin
		if (s_valid && s_ready) begin
			req_addr <= s_addr;
			req_len  <= s_len;
		end
	end

endmodule

`default_nettype wire

/* hdl/last_gen.sv */
// --------------------------------------
// last_gen: length queue and beat
// counter that marks tlast
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module last_gen #(
	parameter int PTR_WIDTH = 6
) (
	input  wire                    aclk,
	input  wire                    rst,
	input  wire axi4_reader_pkg::len_t  cmd_len,
	input  wire                    cmd_valid,
	output logic                   cmd_ready,
	input  wire axi4_reader_pkg::data_t s_data,
	input  wire                    s_valid,
	output logic                   s_ready,
	output axi4_reader_pkg::data_t m_tdata,
	output logic                   m_tlast,
	output logic                   m_tvalid,
	input  wire                    m_tready,
	output logic                   busy
);
	import axi4_reader_pkg::*;

	len_t head_len;
	logic head_valid;
	len_t cnt;
	logic fire;

	stream_fifo #(
		.payload_t (len_t),
		.PTR_WIDTH (PTR_WIDTH)
	) u_len_fifo (
		.aclk    (aclk),
		.rst     (rst),
		.s_data  (cmd_len),
		.s_valid (cmd_valid),
		.s_ready (cmd_ready),
		.m_data  (head_len),
		.m_valid (head_valid),
		.m_ready (fire && m_tlast)
	);

	// data only moves once its length is known
	assign m_tdata  = s_data;
	assign m_tvalid = s_valid && head_valid;
	assign s_ready  = m_tready && head_valid;
	assign m_tlast  = cnt == head_len;
	assign fire     = m_tvalid && m_tready;
	assign busy     = head_valid;

	always_ff @(posedge aclk) begin
		if (rst)
			cnt <= '0;
		else if (fire)
			cnt <= m_tlast ? '0 : cnt + 1'b1;
	end

endmodule

`default_nettype wire

/* hdl/stream_fifo.sv */
// --------------------------------------
// stream_fifo: synchronous fall-through
// FIFO, payload type set per instance
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  PTR_WIDTH = 4
) (
	input  wire           aclk,
	input  wire           rst,
	input  wire payload_t s_data,
	input  wire           s_valid,
	output logic          s_ready,
	output payload_t      m_data,
	output logic          m_valid,
	input  wire           m_ready
);
	localparam int depth = 1 << PTR_WIDTH;

	payload_t mem [depth];

	// extra msb tells full from empty
	logic [PTR_WIDTH:0] wr_ptr;
	logic [PTR_WIDTH:0] rd_ptr;
	logic               wr_en;
	logic               rd_en;

	assign s_ready = (wr_ptr ^ rd_ptr) != {1'b1, {PTR_WIDTH{1'b0}}};
	assign m_valid = wr_ptr != rd_ptr;
	assign m_data  = mem[rd_ptr[PTR_WIDTH-1:0]];

	assign wr_en = s_valid && s_ready;
	assign rd_en = m_valid && m_ready;

	always_ff @(posedge aclk) begin
		if (wr_en)
			mem[wr_ptr[PTR_WIDTH-1:0]] <= s_data;
	end

	always_ff @(posedge aclk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* tb/axi4_reader_properties.sv */
// --------------------------------------
// handshake, burst length and 4 KB
// boundary assertions for axi4_reader
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi4_reader_properties #(
	parameter int ALIGN = 12
) (
	input  wire                          aclk,
	input  wire                          rst,
	input  wire axi4_reader_pkg::axlen_t param_maxlen,
	input  wire axi4_reader_pkg::addr_t  m_axi4_araddr,
	input  wire axi4_reader_pkg::axlen_t m_axi4_arlen,
	input  wire                          m_axi4_arvalid,
	input  wire                          m_axi4_arready,
	input  wire axi4_reader_pkg::data_t  m_axi4_rdata,
	input  wire                          m_axi4_rvalid,
	input  wire                          m_axi4_rready,
	input  wire axi4_reader_pkg::data_t  m_axi4s_tdata,
	input  wire                          m_axi4s_tlast,
	input  wire                          m_axi4s_tvalid,
	input  wire                          m_axi4s_tready
);
	import axi4_reader_pkg::*;

	ar_hold: assert property (@(posedge aclk) disable iff (rst)
		m_axi4_arvalid && !m_axi4_arready |=>
			m_axi4_arvalid && $stable(m_axi4_araddr) && $stable(m_axi4_arlen))
		else $error("AR valid dropped or AR fields changed before arready");

	r_hold: assert property (@(posedge aclk) disable iff (rst)
		m_axi4_rvalid && !m_axi4_rready |=> m_axi4_rvalid && $stable(m_axi4_rdata))
		else $error("R valid dropped or rdata changed before rready");

	stream_hold: assert property (@(posedge aclk) disable iff (rst)
		m_axi4s_tvalid && !m_axi4s_tready |=>
			m_axi4s_tvalid && $stable(m_axi4s_tdata) && $stable(m_axi4s_tlast))
		else $error("stream valid dropped or beat changed before tready");

	// burst end stays inside its 2^ALIGN block
	ar_boundary: assert property (@(posedge aclk) disable iff (rst)
		m_axi4_arvalid |->
			int'(m_axi4_araddr[ALIGN-1:0]) + ((int'(m_axi4_arlen) + 1) << data_size)
				<= (1 << ALIGN))
		else $error("AR burst at %h crosses an aligned boundary", m_axi4_araddr);

	ar_maxlen: assert property (@(posedge aclk) disable iff (rst)
		m_axi4_arvalid |-> m_axi4_arlen <= param_maxlen)
		else $error("arlen %0d above maxlen %0d", m_axi4_arlen, param_maxlen);

endmodule

bind axi4_reader axi4_reader_properties #(
	.ALIGN (ALIGN)
) u_props (
	.aclk           (aclk),
	.rst            (rst),
	.param_maxlen   (param_maxlen),
	.m_axi4_araddr  (m_axi4_araddr),
	.m_axi4_arlen   (m_axi4_arlen),
	.m_axi4_arvalid (m_axi4_arvalid),
	.m_axi4_arready (m_axi4_arready),
	.m_axi4_rdata   (m_axi4_rdata),
	.m_axi4_rvalid  (m_axi4_rvalid),
	.m_axi4_rready  (m_axi4_rready),
	.m_axi4s_tdata  (m_axi4s_tdata),
	.m_axi4s_tlast  (m_axi4s_tlast),
	.m_axi4s_tvalid (m_axi4s_tvalid),
	.m_axi4s_tready (m_axi4s_tready)
);

`default_nettype wire

/* tb/axi4_reader_tb.sv */
// --------------------------------------
// testbench for axi4_reader: request
// table, stream checker, watchdog
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi4_reader_tb;
	import axi4_reader_pkg::*;

	typedef struct {
		string  name;
		addr_t  addr;
		len_t   len;
		addr_t  range_start;
		addr_t  range_end;
		axlen_t maxlen;
		bit     stall;
	} req_t;

	localparam logic [31:0] seed = 32'hbf47_7ba9;
	localparam int n_req = 7;

	// name, address, length-1, range start, range end, maxlen, tready stall
	req_t reqs [n_req] = '{
		'{"short",      32'h0000_1000, 24'd7,   32'h0000_0000, 32'h0001_0000, 8'd255, 1'b0},
		'{"long_ml15",  32'h0000_2000, 24'd199, 32'h0000_0000, 32'h0001_0000, 8'd15,  1'b0},
		'{"cross_4k",   32'h0000_2ff0, 24'd23,  32'h0000_0000, 32'h0001_0000, 8'd255, 1'b0},
		'{"range_wrap", 32'h0000_80c0, 24'd39,  32'h0000_7f00, 32'h0000_8100, 8'd255, 1'b0},
		'{"b2b_a",      32'h0000_4000, 24'd50,  32'h0000_0000, 32'h0001_0000, 8'd7,   1'b1},
		'{"b2b_b",      32'h0000_4fc0, 24'd33,  32'h0000_0000, 32'h0001_0000, 8'd7,   1'b1},
		'{"b2b_c",      32'h0000_a000, 24'd2,   32'h0000_0000, 32'h0001_0000, 8'd7,   1'b1}
	};

	logic   aclk;
	logic   rst;
	logic   busy;
	addr_t  param_range_start;
	addr_t  param_range_end;
	axlen_t param_maxlen;
	addr_t  s_araddr;
	len_t   s_arlen;
	logic   s_arvalid;
	logic   s_arready;
	addr_t  m_axi4_araddr;
	axlen_t m_axi4_arlen;
	logic [2:0] m_axi4_arsize;
	logic [1:0] m_axi4_arburst;
	logic [3:0] m_axi4_arcache;
	logic [2:0] m_axi4_arprot;
	logic   m_axi4_arvalid;
	logic   m_axi4_arready;
	data_t  m_axi4_rdata;
	logic   m_axi4_rlast;
	logic   m_axi4_rvalid;
	logic   m_axi4_rready;
	data_t  m_axi4s_tdata;
	logic   m_axi4s_tlast;
	logic   m_axi4s_tvalid;
	logic   m_axi4s_tready;

	logic [7:0]  slave_rnd;
	logic [31:0] rand_state;
	logic        stall_mode;
	int          data_errs;
	int          last_errs;
	int          ar_errs;
	int          other_errs;
	data_t       exp_data [$];
	logic        exp_last [$];
	int          exp_row [$];

	axi4_reader #(
		.ALIGN          (12),
		.DATA_PTR_WIDTH (4)
	) uut (
		.aclk (aclk), .rst (rst), .busy (busy),
		.param_range_start (param_range_start),
		.param_range_end   (param_range_end),
		.param_maxlen      (param_maxlen),
		.s_araddr (s_araddr), .s_arlen (s_arlen),
		.s_arvalid (s_arvalid), .s_arready (s_arready),
		.m_axi4_araddr (m_axi4_araddr), .m_axi4_arlen (m_axi4_arlen),
		.m_axi4_arsize (m_axi4_arsize), .m_axi4_arburst (m_axi4_arburst),
		.m_axi4_arcache (m_axi4_arcache), .m_axi4_arprot (m_axi4_arprot),
		.m_axi4_arvalid (m_axi4_arvalid), .m_axi4_arready (m_axi4_arready),
		.m_axi4_rdata (m_axi4_rdata), .m_axi4_rlast (m_axi4_rlast),
		.m_axi4_rvalid (m_axi4_rvalid), .m_axi4_rready (m_axi4_rready),
		.m_axi4s_tdata (m_axi4s_tdata), .m_axi4s_tlast (m_axi4s_tlast),
		.m_axi4s_tvalid (m_axi4s_tvalid), .m_axi4s_tready (m_axi4s_tready)
	);

	axi4_slave_model u_slave (
		.aclk (aclk), .rst (rst), .rnd (slave_rnd),
		.araddr (m_axi4_araddr), .arlen (m_axi4_arlen),
		.arvalid (m_axi4_arvalid), .arready (m_axi4_arready),
		.rdata (m_axi4_rdata), .rlast (m_axi4_rlast),
		.rvalid (m_axi4_rvalid), .rready (m_axi4_rready)
	);

	initial aclk = 1'b0;
	always #10 aclk = ~aclk;

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int total_beats();
		int sum;
		sum = 0;
		for (int i = 0; i < n_req; i++)
			sum += int'(reqs[i].len) + 1;
		return sum;
	endfunction

	task automatic print_counts();
		$display("errors: tdata %0d, tlast %0d, ar fields %0d, other %0d",
			data_errs, last_errs, ar_errs, other_errs);
	endtask

	// expected words follow the address and wrap at range end
	task automatic send_request(input int r);
		addr_t word;
		word = reqs[r].addr >> data_size;
		for (int k = 0; k <= int'(reqs[r].len); k++) begin
			exp_data.push_back(data_t'(word));
			exp_last.push_back(k == int'(reqs[r].len));
			exp_row.push_back(r);
			word = word + 1;
			if ((word << data_size) == reqs[r].range_end)
				word = reqs[r].range_start >> data_size;
		end
		s_araddr  = reqs[r].addr;
		s_arlen   = reqs[r].len;
		s_arvalid = 1'b1;
		while (!s_arready)
			@(negedge aclk);
		@(negedge aclk);
		s_arvalid = 1'b0;
	endtask

	task automatic wait_idle();
		while (exp_data.size() != 0 || busy)
			@(negedge aclk);
	endtask

	task automatic check_beat(input data_t data, input logic last);
		data_t exp_d;
		logic  exp_l;
		int    r;
		if (exp_data.size() == 0) begin
			other_errs++;
			$display("stream beat %h arrived with no word outstanding", data);
		end else begin
			exp_d = exp_data.pop_front();
			exp_l = exp_last.pop_front();
			r     = exp_row.pop_front();
			if (data !== exp_d) begin
				data_errs++;
				$display("ERR %s tdata expected %h actual %h", reqs[r].name, exp_d, data);
			end
			if (last !== exp_l) begin
				last_errs++;
				$display("ERR %s tlast expected %b actual %b", reqs[r].name, exp_l, last);
			end
		end
	endtask

	task automatic check_ar_field(input string field, input logic [3:0] exp_v,
			input logic [3:0] act_v);
		if (act_v !== exp_v) begin
			ar_errs++;
			$display("ERR ar_fields %s expected %h actual %h", field, exp_v, act_v);
		end
	endtask

	always @(posedge aclk) begin
		if (!rst && m_axi4s_tvalid && m_axi4s_tready)
			check_beat(m_axi4s_tdata, m_axi4s_tlast);
	end

	// INCR bursts of four-byte beats, cache 0001, prot 000
	always @(posedge aclk) begin
		if (!rst && m_axi4_arvalid && m_axi4_arready) begin
			check_ar_field("arburst", 4'h1, 4'(m_axi4_arburst));
			check_ar_field("arsize", 4'h2, 4'(m_axi4_arsize));
			check_ar_field("arcache", 4'h1, m_axi4_arcache);
			check_ar_field("arprot", 4'h0, 4'(m_axi4_arprot));
		end
		if (!rst && m_axi4_rvalid && !m_axi4_rready) begin
			other_errs++;
			$display("rready was low while read data was waiting");
		end
	end

	// random tready and slave stalls
	initial begin
		rand_state     = seed;
		m_axi4s_tready = 1'b0;
		slave_rnd      <= '0;
		forever begin
			@(negedge aclk);
			rand_state     = next_rand(rand_state);
			slave_rnd      <= rand_state[31:24];
			m_axi4s_tready = stall_mode ? rand_state[21] : 1'b1;
		end
	end

	initial begin
		int limit;
		@(posedge aclk);
		limit = total_beats() * 40 + 2000;
		repeat (limit) @(posedge aclk);
		$display("timeout: run did not finish within %0d cycles", limit);
		print_counts();
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		bit idle_bad;
		rst               <= 1'b1;
		stall_mode        <= 1'b0;
		s_araddr          = '0;
		s_arlen           = '0;
		s_arvalid         = 1'b0;
		param_range_start = '0;
		param_range_end   = '0;
		param_maxlen      = '0;
		data_errs         = 0;
		last_errs         = 0;
		ar_errs           = 0;
		other_errs        = 0;
		idle_bad          = 1'b0;
		repeat (16) @(negedge aclk);
		if (s_arready || m_axi4_arvalid || m_axi4s_tvalid || busy) begin
			other_errs++;
			$display("handshake outputs or busy not low during reset");
		end
		rst <= 1'b0;

		for (int r = 0; r < n_req; r++) begin
			// window and limit only change while idle
			if (r == 0 || reqs[r].range_start != param_range_start ||
					reqs[r].range_end != param_range_end ||
					reqs[r].maxlen != param_maxlen) begin
				wait_idle();
				param_range_start = reqs[r].range_start;
				param_range_end   = reqs[r].range_end;
				param_maxlen      = reqs[r].maxlen;
			end
			stall_mode <= reqs[r].stall;
			send_request(r);
		end

		wait_idle();
		stall_mode <= 1'b0;
		repeat (200) begin
			@(negedge aclk);
			if (busy)
				idle_bad = 1'b1;
		end
		if (idle_bad) begin
			other_errs++;
			$display("busy went high again with no request pending");
		end

		print_counts();
		if (data_errs == 0 && last_errs == 0 && ar_errs == 0 && other_errs == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/axi4_slave_model.sv */
// --------------------------------------
// AXI4 read slave model: queued bursts,
// address-derived data, random stalls
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module axi4_slave_model (
	input  wire                          aclk,
	input  wire                          rst,
	input  wire [7:0]                    rnd,
	input  wire axi4_reader_pkg::addr_t  araddr,
	input  wire axi4_reader_pkg::axlen_t arlen,
	input  wire                          arvalid,
	output logic                         arready,
	output axi4_reader_pkg::data_t       rdata,
	output logic                         rlast,
	output logic                         rvalid,
	input  wire                          rready
);
	import axi4_reader_pkg::*;

	addr_t  q_addr [$];
	axlen_t q_len [$];
	logic   ar_hs;
	logic   r_hs;
	addr_t  ar_addr_q;
	axlen_t ar_len_q;
	int     beat;
	int     wait_cnt;

	initial begin
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
	end

	// handshakes as seen at the clock edge
	always @(posedge aclk) begin
		ar_hs     <= arvalid && arready;
		ar_addr_q <= araddr;
		ar_len_q  <= arlen;
		r_hs      <= rvalid && rready;
	end

	always @(negedge aclk) begin
		if (rst) begin
			q_addr.delete();
			q_len.delete();
			beat     = 0;
			wait_cnt = 0;
			arready  = 1'b0;
			rvalid   = 1'b0;
			rlast    = 1'b0;
			rdata    = '0;
		end else begin
			if (r_hs) begin
				rvalid = 1'b0;
				if (rlast) begin
					void'(q_addr.pop_front());
					void'(q_len.pop_front());
					beat     = 0;
					wait_cnt = rnd[2:0];
				end else begin
					beat = beat + 1;
				end
			end
			if (ar_hs) begin
				if (q_addr.size() == 0)
					wait_cnt = rnd[2:0];
				q_addr.push_back(ar_addr_q);
				q_len.push_back(ar_len_q);
			end
			// random gap before a burst, then random beat stalls
			if (wait_cnt != 0) begin
				wait_cnt = wait_cnt - 1;
			end else if (!rvalid && q_addr.size() != 0 && rnd[7:6] != 2'b00) begin
				rvalid = 1'b1;
				rdata  = data_t'((q_addr[0] >> data_size) + addr_t'(beat));
				rlast  = beat == int'(q_len[0]);
			end
			arready = q_addr.size() < 4;
		end
	end

endmodule

`default_nettype wire
